//--- bench/cpu_tb.sv
`include "cpu_config.svh"

module cpu_tb;

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_INSTR = 200;
	localparam int FAULT_CYCLES = 70;
	localparam int TIMEOUT = (NUM_INSTR * 20 + 2 * RESET_CYCLES + FAULT_CYCLES) * CLOCK_PERIOD;
	localparam logic [31:0] END_PC = `CPU_RESET_VECTOR + 32'(4 * NUM_INSTR);

	typedef enum logic [4:0] {
		K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLLI, K_SRLI,
		K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
		K_LUI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_ILLEGAL
	} kind_t;

	// One expected data bus access
	typedef struct packed {
		logic rw;
		logic [31:0] address;
		logic [31:0] data;
	} access_t;

	logic clock;
	logic rst;
	logic ibus_request;
	logic ibus_ready;
	logic [31:0] ibus_address;
	logic [31:0] ibus_rdata;
	logic dbus_rw;
	logic dbus_request;
	logic dbus_ready;
	logic [31:0] dbus_address;
	logic [`CPU_XLEN-1:0] dbus_rdata;
	logic [`CPU_XLEN-1:0] dbus_wdata;
	logic fault;

	// Program image as fields for the model and as words for the bus
	kind_t prog_kind [256];
	logic [4:0] prog_rd [256];
	logic [4:0] prog_rs1 [256];
	logic [4:0] prog_rs2 [256];
	logic [31:0] prog_imm [256];
	logic [31:0] prog_word [256];

	logic [31:0] model_regs [32];
	logic [31:0] model_pc;
	logic [31:0] model_mem [logic [31:0]];
	logic [31:0] dmem [logic [31:0]];
	access_t expected_q [$];
	logic [31:0] rng_state = 32'd98562;
	logic running;
	logic fault_fetched;
	int end_fetches;
	int errors;
	int checks;

	cpu UUT (
		.i_clock(clock),
		.i_rst(rst),
		.o_ibus_request(ibus_request),
		.i_ibus_ready(ibus_ready),
		.o_ibus_address(ibus_address),
		.i_ibus_rdata(ibus_rdata),
		.o_dbus_rw(dbus_rw),
		.o_dbus_request(dbus_request),
		.i_dbus_ready(dbus_ready),
		.o_dbus_address(dbus_address),
		.i_dbus_rdata(dbus_rdata),
		.o_dbus_wdata(dbus_wdata),
		.o_fault(fault)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout: the core stopped making progress before the tests ended");
		$display("Testbench failed");
		$finish;
	end

	function logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Contents of data memory never written
	function automatic logic [31:0] fill_word(input logic [31:0] address);
		return {address[15:0], address[31:16]} ^ 32'hC3A5_5A3C;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	//======================================================================
	// Program construction

	function automatic logic [31:0] encode(input kind_t k, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
		logic [2:0] f3;
		case (k)
			K_ANDI, K_AND: f3 = 3'b111;
			K_ORI, K_OR: f3 = 3'b110;
			K_XORI, K_XOR: f3 = 3'b100;
			K_SLLI, K_BNE: f3 = 3'b001;
			K_SRLI: f3 = 3'b101;
			K_SLT, K_LW, K_SW: f3 = 3'b010;
			default: f3 = 3'b000;
		endcase
		case (k)
			K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLLI, K_SRLI:
				return {imm[11:0], rs1, f3, rd, 7'b0010011};
			K_ADD, K_AND, K_OR, K_XOR, K_SLT:
				return {7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
			K_SUB: return {7'b0100000, rs2, rs1, f3, rd, 7'b0110011};
			K_LUI: return {imm[31:12], rd, 7'b0110111};
			K_LW: return {imm[11:0], rs1, f3, rd, 7'b0000011};
			K_SW: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
			K_BEQ, K_BNE:
				return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
			K_JAL: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	task automatic place_instruction(input int index, input kind_t k, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
		prog_kind[index] = k;
		prog_rd[index] = rd;
		prog_rs1[index] = rs1;
		prog_rs2[index] = rs2;
		prog_imm[index] = imm;
		prog_word[index] = encode(k, rd, rs1, rs2, imm);
	endtask

	task automatic build_random_program();
		kind_t k;
		logic [31:0] r;
		logic [4:0] rd;
		int hop;
		// Write to x0, then store x0
		place_instruction(0, K_ADDI, 5'd0, 5'd2, 5'd0, 32'd4);
		place_instruction(1, K_SW, 5'd0, 5'd2, 5'd0, 32'hFFFF_FFFC);
		for (int i = 2; i < NUM_INSTR; i++) begin
			k = kind_t'(5'(next_random() % 18));
			r = next_random();
			rd = (r[4:0] == 5'd2) ? 5'd3 : r[4:0];
			hop = 1 + int'(r[27:25]);
			if (i + hop > NUM_INSTR)
				hop = NUM_INSTR - i;
			case (k)
				K_SLLI, K_SRLI: place_instruction(i, k, rd, r[9:5], r[14:10], {27'b0, r[19:15]});
				K_LUI: place_instruction(i, k, rd, 5'd0, 5'd0, {r[31:12], 12'b0});
				K_LW: begin
					place_instruction(i, k, rd, 5'd2, r[14:10], {{25{r[21]}}, r[21:17], 2'b00});
					// Loaded register goes straight back out on the data bus
					if (i + 1 < NUM_INSTR) begin
						i++;
						place_instruction(i, K_SW, 5'd0, 5'd2, rd,
							{{25{r[30]}}, r[30:26], 2'b00});
					end
				end
				K_SW:
					place_instruction(i, k, rd, 5'd2, r[14:10], {{25{r[21]}}, r[21:17], 2'b00});
				K_BEQ, K_BNE, K_JAL: place_instruction(i, k, rd, r[9:5], r[14:10], 32'(hop * 4));
				default: place_instruction(i, k, rd, r[9:5], r[14:10], {{20{r[31]}}, r[31:20]});
			endcase
		end
		// Final jump to itself
		place_instruction(NUM_INSTR, K_JAL, 5'd0, 5'd0, 5'd0, 32'd0);
	endtask

	task automatic build_fault_program();
		place_instruction(0, K_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
		place_instruction(1, K_SW, 5'd0, 5'd2, 5'd1, 32'd0);
		place_instruction(2, K_ILLEGAL, 5'd0, 5'd0, 5'd0, 32'd0);
		place_instruction(3, K_JAL, 5'd0, 5'd0, 5'd0, 32'd0);
	endtask

	//======================================================================
	// Instruction-set model stepped once per fetch

	task automatic run_model();
		int index;
		kind_t k;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] result;
		logic [31:0] address;
		logic [31:0] next_pc;
		logic write;
		index = int'((model_pc - `CPU_RESET_VECTOR) >> 2);
		if (index > NUM_INSTR) begin
			errors++;
			$display("Model program counter %h left the program", model_pc);
		end else begin
			k = prog_kind[index];
			a = model_regs[prog_rs1[index]];
			b = model_regs[prog_rs2[index]];
			imm = prog_imm[index];
			address = a + imm;
			next_pc = model_pc + 32'd4;
			result = 32'd0;
			write = 1'b1;
			case (k)
				K_ADDI: result = a + imm;
				K_ANDI: result = a & imm;
				K_ORI: result = a | imm;
				K_XORI: result = a ^ imm;
				K_SLLI: result = a << imm[4:0];
				K_SRLI: result = a >> imm[4:0];
				K_ADD: result = a + b;
				K_SUB: result = a - b;
				K_AND: result = a & b;
				K_OR: result = a | b;
				K_XOR: result = a ^ b;
				K_SLT: result = {31'b0, $signed(a) < $signed(b)};
				K_LUI: result = imm;
				K_LW: begin
					result = model_mem.exists(address) ? model_mem[address] : fill_word(address);
					expected_q.push_back({1'b0, address, 32'd0});
				end
				K_SW: begin
					write = 1'b0;
					model_mem[address] = b;
					expected_q.push_back({1'b1, address, b});
				end
				K_BEQ, K_BNE: begin
					write = 1'b0;
					if ((a == b) != (k == K_BNE))
						next_pc = model_pc + imm;
				end
				K_JAL: begin
					result = next_pc;
					next_pc = model_pc + imm;
				end
				default: begin
					write = 1'b0;
					fault_fetched = 1'b1;
				end
			endcase
			if (write && prog_rd[index] != 5'd0)
				model_regs[prog_rd[index]] = result;
			model_pc = next_pc;
		end
	endtask

	//======================================================================
	// Bus responders

	task automatic serve_data_access();
		access_t expected;
		if (expected_q.size() == 0) begin
			errors++;
			$display("Unexpected data bus access at address %h", dbus_address);
		end else begin
			expected = expected_q.pop_front();
			check_value("o_dbus_rw", {31'b0, dbus_rw}, {31'b0, expected.rw});
			check_value("o_dbus_address", dbus_address, expected.address);
			if (expected.rw)
				check_value("o_dbus_wdata", dbus_wdata, expected.data);
		end
		if (dbus_rw)
			dmem[dbus_address] = dbus_wdata;
		else
			dbus_rdata = dmem.exists(dbus_address) ? dmem[dbus_address] : fill_word(dbus_address);
	endtask

	initial begin
		int wait_cycles;
		int index;
		ibus_ready = 1'b0;
		ibus_rdata = 32'd0;
		wait_cycles = -1;
		forever begin
			@(posedge clock);
			#1;
			if (ibus_ready) begin
				ibus_ready = 1'b0;
			end else if (running && ibus_request) begin
				if (wait_cycles < 0)
					wait_cycles = int'(next_random() % 4);
				if (wait_cycles == 0) begin
					check_value("o_ibus_address", ibus_address, model_pc);
					index = int'((ibus_address - `CPU_RESET_VECTOR) >> 2);
					ibus_rdata = (index <= NUM_INSTR) ? prog_word[index] : 32'hFFFF_FFFF;
					if (ibus_address == END_PC)
						end_fetches++;
					run_model();
					ibus_ready = 1'b1;
					wait_cycles = -1;
				end else begin
					wait_cycles--;
				end
			end
		end
	end

	initial begin
		int wait_cycles;
		dbus_ready = 1'b0;
		dbus_rdata = '0;
		wait_cycles = -1;
		forever begin
			@(posedge clock);
			#1;
			if (dbus_ready) begin
				dbus_ready = 1'b0;
			end else if (running && dbus_request) begin
				if (wait_cycles < 0)
					wait_cycles = int'(next_random() % 4);
				if (wait_cycles == 0) begin
					serve_data_access();
					dbus_ready = 1'b1;
					wait_cycles = -1;
				end else begin
					wait_cycles--;
				end
			end
		end
	end

	//======================================================================
	// Sequence

	task automatic reset_dut();
		@(posedge clock);
		#1;
		rst = 1'b1;
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'd0;
		model_regs[2] = `CPU_STACK_POINTER;
		model_pc = `CPU_RESET_VECTOR;
		model_mem.delete();
		dmem.delete();
		expected_q.delete();
		end_fetches = 0;
		fault_fetched = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		check_value("o_ibus_request", {31'b0, ibus_request}, 32'd0);
		check_value("o_dbus_request", {31'b0, dbus_request}, 32'd0);
		check_value("o_dbus_rw", {31'b0, dbus_rw}, 32'd0);
		check_value("o_fault", {31'b0, fault}, 32'd0);
		rst = 1'b0;
	endtask

	initial begin
		int cycles;
		int late_requests;
		rst = 1'b1;
		running = 1'b0;
		errors = 0;
		checks = 0;
		build_random_program();
		reset_dut();
		running = 1'b1;
		// Runs until the final self jump has been fetched twice
		while (end_fetches < 2)
			@(posedge clock);
		running = 1'b0;
		repeat (4) @(posedge clock);
		check_value("o_fault", {31'b0, fault}, 32'd0);
		check_value("pending data accesses", 32'(expected_q.size()), 32'd0);

		// Second run with one illegal word
		build_fault_program();
		reset_dut();
		running = 1'b1;
		while (!fault_fetched)
			@(posedge clock);
		running = 1'b0;
		cycles = 0;
		while (!fault && cycles < 20) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!fault) begin
			errors++;
			$display("o_fault did not rise after the illegal instruction");
		end
		late_requests = 0;
		repeat (FAULT_CYCLES - 20) begin
			@(posedge clock);
			#1;
			if (ibus_request)
				late_requests++;
		end
		if (late_requests != 0) begin
			errors++;
			$display("Instruction bus request seen after the fault for %0d cycles", late_requests);
		end
		check_value("pending data accesses", 32'(expected_q.size()), 32'd0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- cpu.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_registers.sv
verilog/cpu_execute.sv
verilog/cpu.sv
bench/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build the cpu testbench with Verilator, run it, then look for the fail message
verilator --binary --timing --top-module cpu_tb -f cpu.f -o cpu_sim \
	&& ./obj_dir/cpu_sim > sim.log \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

//--- verilog/cpu.sv
`include "cpu_config.svh"

module cpu (
	input logic i_clock,
	input logic i_rst,

	// Instruction bus
	output logic o_ibus_request,
	input logic i_ibus_ready,
	output logic [31:0] o_ibus_address,
	input logic [31:0] i_ibus_rdata,

	// Data bus
	output logic o_dbus_rw,
	output logic o_dbus_request,
	input logic i_dbus_ready,
	output logic [31:0] o_dbus_address,
	input logic [`CPU_XLEN-1:0] i_dbus_rdata,
	output logic [`CPU_XLEN-1:0] o_dbus_wdata,

	output logic o_fault
);

	cpu_pkg::fetch_data_t fetch_data;
	cpu_pkg::decode_data_t decode_data;
	cpu_pkg::retire_data_t retire_data;
	logic [`CPU_XLEN-1:0] rs1;
	logic [`CPU_XLEN-1:0] rs2;

	//======================================================================
	// Fetch

	cpu_fetch fetch (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_retire(retire_data),
		.i_fault(o_fault),
		.o_ibus_request(o_ibus_request),
		.i_ibus_ready(i_ibus_ready),
		.o_ibus_address(o_ibus_address),
		.i_ibus_rdata(i_ibus_rdata),
		.o_data(fetch_data)
	);

	//======================================================================
	// Decode and register read, side by side

	cpu_decode decode (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_data(fetch_data),
		.o_data(decode_data),
		.o_fault(o_fault)
	);

	cpu_registers registers (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_data(fetch_data),
		.i_retire(retire_data),
		.o_rs1(rs1),
		.o_rs2(rs2)
	);

	//======================================================================
	// Execute, memory and writeback

	cpu_execute execute (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_data(decode_data),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_dbus_rw(o_dbus_rw),
		.o_dbus_request(o_dbus_request),
		.i_dbus_ready(i_dbus_ready),
		.o_dbus_address(o_dbus_address),
		.i_dbus_rdata(i_dbus_rdata),
		.o_dbus_wdata(o_dbus_wdata),
		.o_retire(retire_data)
	);

endmodule

//--- verilog/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Address of the first instruction fetch
`define CPU_RESET_VECTOR 32'h0000_0000

// Reset value of x2
`define CPU_STACK_POINTER 32'h1000_0400

// Register and data bus width
`define CPU_XLEN 32

`endif

//--- verilog/cpu_decode.sv
module cpu_decode (
	input logic i_clock,
	input logic i_rst,

	input cpu_pkg::fetch_data_t i_data,
	output cpu_pkg::decode_data_t o_data,
	output logic o_fault
);

	logic [31:0] instr;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic illegal;
	cpu_pkg::decode_data_t next;

	assign instr = i_data.instruction;
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	//======================================================================
	// Immediates per format

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		next = '0;
		next.pc = i_data.pc;
		next.rd = instr[11:7];
		next.alu_op = cpu_pkg::ALU_ADD;
		illegal = 1'b0;
		case (cpu_pkg::opcode_t'(instr[6:0]))
			cpu_pkg::OP_IMM: begin
				next.use_imm = 1'b1;
				next.imm = imm_i;
				next.reg_write = 1'b1;
				case (funct3)
					3'b000: next.alu_op = cpu_pkg::ALU_ADD;
					3'b111: next.alu_op = cpu_pkg::ALU_AND;
					3'b110: next.alu_op = cpu_pkg::ALU_OR;
					3'b100: next.alu_op = cpu_pkg::ALU_XOR;
					3'b001: begin
						next.alu_op = cpu_pkg::ALU_SLL;
						illegal = (funct7 != 7'b0);
					end
					3'b101: begin
						next.alu_op = cpu_pkg::ALU_SRL;
						illegal = (funct7 != 7'b0);
					end
					default: illegal = 1'b1;
				endcase
			end
			cpu_pkg::OP: begin
				next.reg_write = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: next.alu_op = cpu_pkg::ALU_ADD;
					10'b0100000_000: next.alu_op = cpu_pkg::ALU_SUB;
					10'b0000000_111: next.alu_op = cpu_pkg::ALU_AND;
					10'b0000000_110: next.alu_op = cpu_pkg::ALU_OR;
					10'b0000000_100: next.alu_op = cpu_pkg::ALU_XOR;
					10'b0000000_010: next.alu_op = cpu_pkg::ALU_SLT;
					default: illegal = 1'b1;
				endcase
			end
			cpu_pkg::LUI: begin
				next.alu_op = cpu_pkg::ALU_PASS_B;
				next.use_imm = 1'b1;
				next.imm = imm_u;
				next.reg_write = 1'b1;
			end
			cpu_pkg::LOAD: begin
				// Address is rs1 + imm through the ALU
				next.use_imm = 1'b1;
				next.imm = imm_i;
				next.reg_write = 1'b1;
				next.load = 1'b1;
				illegal = (funct3 != 3'b010);
			end
			cpu_pkg::STORE: begin
				next.use_imm = 1'b1;
				next.imm = imm_s;
				next.store = 1'b1;
				illegal = (funct3 != 3'b010);
			end
			cpu_pkg::BRANCH: begin
				next.imm = imm_b;
				next.branch = 1'b1;
				next.branch_ne = funct3[0];
				illegal = (funct3[2:1] != 2'b00);
			end
			cpu_pkg::JAL: begin
				next.imm = imm_j;
				next.jump = 1'b1;
				next.reg_write = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
		next.valid = !illegal;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_data.valid <= 1'b0;
			o_fault <= 1'b0;
		end else begin
			if (i_data.valid) begin
				o_data <= next;
			end else begin
				o_data.valid <= 1'b0;
			end
			// Sticky until reset
			if (i_data.valid && illegal) begin
				o_fault <= 1'b1;
			end
		end
	end

endmodule

//--- verilog/cpu_execute.sv
`include "cpu_config.svh"

module cpu_execute (
	input logic i_clock,
	input logic i_rst,

	input cpu_pkg::decode_data_t i_data,
	input logic [`CPU_XLEN-1:0] i_rs1,
	input logic [`CPU_XLEN-1:0] i_rs2,

	// Data bus
	output logic o_dbus_rw,
	output logic o_dbus_request,
	input logic i_dbus_ready,
	output logic [31:0] o_dbus_address,
	input logic [`CPU_XLEN-1:0] i_dbus_rdata,
	output logic [`CPU_XLEN-1:0] o_dbus_wdata,

	output cpu_pkg::retire_data_t o_retire
);

	typedef enum logic {
		EXECUTE,
		MEMORY
	} state_t;

	state_t state;
	logic [`CPU_XLEN-1:0] alu_b;
	logic [`CPU_XLEN-1:0] alu_result;
	logic [31:0] pc_plus4;
	logic [31:0] target;
	logic taken;
	logic is_memory;

	//======================================================================
	// ALU

	assign alu_b = i_data.use_imm ? i_data.imm : i_rs2;

	always_comb begin
		case (i_data.alu_op)
			cpu_pkg::ALU_ADD: alu_result = i_rs1 + alu_b;
			cpu_pkg::ALU_SUB: alu_result = i_rs1 - alu_b;
			cpu_pkg::ALU_AND: alu_result = i_rs1 & alu_b;
			cpu_pkg::ALU_OR: alu_result = i_rs1 | alu_b;
			cpu_pkg::ALU_XOR: alu_result = i_rs1 ^ alu_b;
			cpu_pkg::ALU_SLT: alu_result = {{(`CPU_XLEN-1){1'b0}}, $signed(i_rs1) < $signed(alu_b)};
			cpu_pkg::ALU_SLL: alu_result = i_rs1 << alu_b[4:0];
			cpu_pkg::ALU_SRL: alu_result = i_rs1 >> alu_b[4:0];
			cpu_pkg::ALU_PASS_B: alu_result = alu_b;
			default: alu_result = '0;
		endcase
	end

	// Branch and jump resolution
	assign pc_plus4 = i_data.pc + 32'd4;
	assign target = i_data.pc + i_data.imm;
	assign taken = i_data.jump || (i_data.branch && ((i_rs1 == i_rs2) ^ i_data.branch_ne));
	assign is_memory = i_data.load || i_data.store;

	//======================================================================
	// Sequencing and data bus

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= EXECUTE;
			o_dbus_rw <= 1'b0;
			o_retire.done <= 1'b0;
			o_retire.jump <= 1'b0;
			o_retire.reg_write <= 1'b0;
		end else begin
			o_retire.done <= 1'b0;
			case (state)
				EXECUTE: begin
					if (i_data.valid && is_memory) begin
						state <= MEMORY;
						o_dbus_rw <= i_data.store;
						o_dbus_address <= alu_result;
						o_dbus_wdata <= i_rs2;
					end else if (i_data.valid) begin
						o_retire.done <= 1'b1;
						o_retire.jump <= taken;
						o_retire.next_pc <= taken ? target : pc_plus4;
						o_retire.reg_write <= i_data.reg_write;
						o_retire.rd <= i_data.rd;
						// JAL links the return address
						o_retire.wdata <= i_data.jump ? pc_plus4 : alu_result;
					end
				end
				MEMORY: begin
					// Decode output holds steady while waiting on the bus
					if (i_dbus_ready) begin
						state <= EXECUTE;
						o_dbus_rw <= 1'b0;
						o_retire.done <= 1'b1;
						o_retire.jump <= 1'b0;
						o_retire.next_pc <= pc_plus4;
						o_retire.reg_write <= i_data.load;
						o_retire.rd <= i_data.rd;
						o_retire.wdata <= i_dbus_rdata;
					end
				end
				default: state <= EXECUTE;
			endcase
		end
	end

	assign o_dbus_request = (state == MEMORY);

endmodule

//--- verilog/cpu_fetch.sv
`include "cpu_config.svh"

module cpu_fetch (
	input logic i_clock,
	input logic i_rst,

	// Retire feedback
	input cpu_pkg::retire_data_t i_retire,
	input logic i_fault,

	// Instruction bus
	output logic o_ibus_request,
	input logic i_ibus_ready,
	output logic [31:0] o_ibus_address,
	input logic [31:0] i_ibus_rdata,

	output cpu_pkg::fetch_data_t o_data
);

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT_RETIRE
	} state_t;

	state_t state;
	logic [31:0] pc;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= IDLE;
			pc <= `CPU_RESET_VECTOR;
			o_data.valid <= 1'b0;
		end else begin
			// Valid is a single cycle pulse
			o_data.valid <= 1'b0;
			case (state)
				IDLE: begin
					if (!i_fault) begin
						state <= REQUEST;
					end
				end
				REQUEST: begin
					if (i_ibus_ready) begin
						o_data.valid <= 1'b1;
						o_data.pc <= pc;
						o_data.instruction <= i_ibus_rdata;
						state <= WAIT_RETIRE;
					end
				end
				WAIT_RETIRE: begin
					// Illegal instruction never retires, park here
					if (i_fault) begin
						state <= IDLE;
					end else if (i_retire.done) begin
						pc <= i_retire.jump ? i_retire.next_pc : pc + 32'd4;
						state <= REQUEST;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign o_ibus_request = (state == REQUEST);
	assign o_ibus_address = pc;

endmodule

//--- verilog/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_t;

	//======================================================================
	// Stage payloads

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [31:0] instruction;
	} fetch_data_t;

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		alu_op_t alu_op;
		logic use_imm;
		logic [`CPU_XLEN-1:0] imm;
		logic [4:0] rd;
		logic reg_write;
		logic load;
		logic store;
		logic branch;
		logic branch_ne;
		logic jump;
	} decode_data_t;

	// End of one instruction, seen by fetch and the register file
	typedef struct packed {
		logic done;
		logic jump;
		logic [31:0] next_pc;
		logic reg_write;
		logic [4:0] rd;
		logic [`CPU_XLEN-1:0] wdata;
	} retire_data_t;

endpackage

//--- verilog/cpu_registers.sv
`include "cpu_config.svh"

module cpu_registers (
	input logic i_clock,
	input logic i_rst,

	input cpu_pkg::fetch_data_t i_data,
	input cpu_pkg::retire_data_t i_retire,

	output logic [`CPU_XLEN-1:0] o_rs1,
	output logic [`CPU_XLEN-1:0] o_rs2
);

	logic [`CPU_XLEN-1:0] regs [32];
	logic [4:0] rs1_index;
	logic [4:0] rs2_index;

	assign rs1_index = i_data.instruction[19:15];
	assign rs2_index = i_data.instruction[24:20];

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			regs[2] <= `CPU_STACK_POINTER;
		end else if (i_retire.done && i_retire.reg_write && i_retire.rd != 5'd0) begin
			// x0 is never written, so it reads as zero
			regs[i_retire.rd] <= i_retire.wdata;
		end
	end

	// Operands line up with decode output
	always_ff @(posedge i_clock) begin
		if (i_data.valid) begin
			o_rs1 <= regs[rs1_index];
			o_rs2 <= regs[rs2_index];
		end
	end

endmodule
